// File: Makefile
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module execute_tb -Mdir obj_dir -o execute_sim

run: compile
	./obj_dir/execute_sim > $(LOG) 2>&1; cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/clock_gen.sv
//////////////////////////////////////////////////////////////////////
// Bench clock and reset, 40 ns period, reset held for 4 edges
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 40,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2 rst = 1'b0;                              // Same skew as the stimulus
    end

endmodule

// File: bench/execute_tb.sv
//////////////////////////////////////////////////////////////////////
// Execute stage testbench: LFSR issues one per cycle, a reference
// model predicts the registered outputs, a compare process checks
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "execute_config.svh"

module execute_tb;
    import execute_pkg::*;

    localparam int N_TESTS      = 800;
    localparam int PERIOD_NS    = 40;
    localparam int RESET_CYCLES = 4;
    localparam int WATCHDOG_NS  = (N_TESTS + 20) * PERIOD_NS + 1000;
    localparam logic [`XLEN-1:0] SIGN = {1'b1, {(`XLEN-1){1'b0}}};

    // All registered outputs of the stage in one word
    typedef struct packed {
        wb_t       wb;
        mem_req_t  mem;
        redirect_t redir;
        csr_req_t  csr;
    } stage_out_t;

    logic        clk;
    logic        rst;
    issue_t      issue;
    privilege_t  privilege;
    wb_t         wb;
    mem_req_t    mem_req;
    redirect_t   redirect;
    csr_req_t    csr_req;

    issue_t      sent_q[$];                         // Issues awaiting their result
    privilege_t  priv_q[$];
    logic [31:0] lfsr_state = 32'ha988;
    int          errors  = 0;
    int          checks  = 0;
    int          checked = 0;                       // Issues compared so far

    clock_gen #(.PERIOD_NS(PERIOD_NS), .RESET_CYCLES(RESET_CYCLES)) u_clock (
        .clk(clk), .rst(rst)
    );

    execute DUT (
        .clk(clk), .rst(rst), .issue(issue), .privilege(privilege),
        .wb(wb), .mem_req(mem_req), .redirect(redirect), .csr_req(csr_req)
    );

    //////////////////////////////////////////////////////////////////////
    // Random stimulus

    // Taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            r = {r[30:0], lfsr_state[0]};           // One step per bit
        end
        return r;
    endfunction

    function automatic logic [`XLEN-1:0] boundary_value();
        case (2'(rand_bits(2)))
            2'd0:    return SIGN;                   // Most negative
            2'd1:    return ~SIGN;                  // Most positive
            2'd2:    return '1;                     // Minus one
            default: return '0;
        endcase
    endfunction

    function automatic privilege_t pick_privilege();
        case (2'(rand_bits(2)))
            2'd0:    return PRIV_USER;
            2'd1:    return PRIV_SUPERVISOR;
            default: return PRIV_MACHINE;
        endcase
    endfunction

    // Valid issues held while reset is high, each would raise strobes
    function automatic issue_t reset_issue(input int k);
        issue_t it;
        it       = '0;
        it.valid = 1'b1;
        case (k)
            0: begin
                it.unit = XU_BRANCH;
                it.op   = OP6;                      // JAL, jump and link write
            end
            1: begin
                it.unit = XU_MEMORY;
                it.op   = OP0;                      // Load read
            end
            2: begin
                it.unit = XU_MEMORY;
                it.op   = OP5;                      // Word store lanes
            end
            default: begin
                it.unit  = XU_CSR;
                it.op    = OP0;
                it.instr = 32'h3000_8080;           // CSR 0x300, rs1 1, rd 1
            end
        endcase
        return it;
    endfunction

    function automatic issue_t make_issue();
        issue_t     it;
        logic [2:0] u;
        logic [1:0] mode;
        u        = 3'(rand_bits(3));
        mode     = 2'(rand_bits(2));
        it.valid = (3'(rand_bits(3)) != 3'd0);      // About one in eight idle
        it.unit  = (u == 3'd7) ? XU_NONE : xu_class'(u);
        it.op    = sub_op'(3'(rand_bits(3)));
        case (mode)
            2'd0: begin
                it.op_a = rand_bits(32);
                it.op_b = rand_bits(32);
            end
            2'd1: begin                             // Equal operands
                it.op_a = rand_bits(32);
                it.op_b = it.op_a;
            end
            2'd2: begin                             // Sign boundaries
                it.op_a = boundary_value();
                it.op_b = boundary_value();
            end
            default: begin                          // Small B, shift amounts
                it.op_a = rand_bits(32);
                it.op_b = rand_bits(5);
            end
        endcase
        it.offset     = rand_bits(32);
        it.npc        = rand_bits(32) & ~`XLEN'd3;
        it.store_data = rand_bits(32);
        it.instr      = rand_bits(32);
        if (2'(rand_bits(2)) == 2'd0)
            it.instr[11:7] = 5'd0;                  // rd zero
        if (2'(rand_bits(2)) == 2'd0)
            it.instr[19:15] = 5'd0;                 // rs1 zero
        return it;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model, one issue in, next registered outputs out

    function automatic stage_out_t expect_out(input issue_t it, input privilege_t pv,
                                              input stage_out_t prev);
        stage_out_t       e;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        logic [`XLEN-1:0] sum;
        logic [`XLEN-1:0] alu;
        logic [`XLEN-1:0] wdata;
        logic [`XLEN-1:0] wb_val;
        logic [4:0]       sh;
        logic [4:0]       rd;
        logic [4:0]       rs1;
        logic [11:0]      caddr;
        logic [3:0]       strobe;
        logic             lts;
        logic             ltu;
        logic             taken;
        logic             load;
        logic             want_rd;
        logic             want_wr;
        logic             exc;
        logic             wb_en;
        e     = prev;                               // Data fields hold when idle
        a     = it.op_a;
        b     = it.op_b;
        sum   = a + b;
        sh    = b[4:0];
        ltu   = a < b;
        lts   = (a ^ SIGN) < (b ^ SIGN);            // Signed via flipped sign bits
        rd    = it.instr[11:7];
        rs1   = it.instr[19:15];
        caddr = it.instr[31:20];

        alu = '0;
        if (it.unit == XU_ADDER) begin
            if (it.op == OP3)
                alu = `XLEN'(lts);
            else if (it.op == OP2)
                alu = `XLEN'(ltu);
            else if (it.op == OP1)
                alu = a + ~b + `XLEN'd1;            // Two's complement subtract
            else
                alu = sum;
        end else if (it.unit == XU_LOGIC) begin
            if (it.op == OP0)
                alu = a ^ b;
            else if (it.op == OP1)
                alu = a | b;
            else
                alu = a & b;
        end else if (it.unit == XU_SHIFT) begin
            if (it.op == OP0)
                alu = a << sh;
            else if (it.op == OP1)
                alu = a >> sh;
            else
                alu = (a >> sh) | (a[`XLEN-1] ? ~({`XLEN{1'b1}} >> sh) : '0);
        end

        case (it.op)
            OP0:     taken = (a == b);
            OP1:     taken = (a != b);
            OP2:     taken = lts;
            OP3:     taken = ltu;
            OP4:     taken = !lts;
            OP5:     taken = !ltu;
            default: taken = 1'b1;                  // JAL, JALR
        endcase

        load = (it.op <= OP4);
        case (it.op)
            OP7:     {strobe, wdata} = {4'b0001, `XLEN'(it.store_data[7:0])};
            OP6:     {strobe, wdata} = {4'b0011, `XLEN'(it.store_data[15:0])};
            OP5:     {strobe, wdata} = {4'b1111, it.store_data};
            default: {strobe, wdata} = {4'b0000, `XLEN'd0};
        endcase

        want_wr = 1'b0;
        want_rd = 1'b0;
        if (it.op <= OP1) begin
            want_wr = 1'b1;
            want_rd = (rd != 5'd0);
        end else if (it.op <= OP5) begin
            want_rd = 1'b1;
            want_wr = (rs1 != 5'd0);
        end
        exc = ((caddr[11:10] == 2'b11) && want_wr) || (2'(pv) < caddr[9:8]);

        case (it.unit)
            XU_ADDER, XU_LOGIC, XU_SHIFT: {wb_en, wb_val} = {1'b1, alu};
            XU_BRANCH: {wb_en, wb_val} = {it.op >= OP6, it.npc + `XLEN'd4};
            XU_MEMORY: {wb_en, wb_val} = {load, `XLEN'd0};
            XU_CSR:    {wb_en, wb_val} = {want_rd && !exc, `XLEN'd0};
            default:   {wb_en, wb_val} = {1'b0, `XLEN'd0};
        endcase

        e.wb.valid      = it.valid;
        e.wb.we         = it.valid && wb_en;
        e.mem.read      = it.valid && it.unit == XU_MEMORY && load;
        e.mem.we_mem    = (it.valid && it.unit == XU_MEMORY) ? strobe : 4'b0000;
        e.redir.jump    = it.valid && it.unit == XU_BRANCH && taken;
        e.csr.rd_en     = it.valid && it.unit == XU_CSR && want_rd && !exc;
        e.csr.wr_en     = it.valid && it.unit == XU_CSR && want_wr && !exc;
        e.csr.exception = it.valid && it.unit == XU_CSR && exc;
        if (it.valid) begin
            e.wb.result         = wb_val;
            e.mem.read_address  = load ? sum : '0;
            e.mem.write_address = sum;
            e.mem.write_data    = wdata;
            if (it.op == OP6)
                e.redir.target = sum;
            else if (it.op == OP7)
                e.redir.target = sum & ~`XLEN'd1;
            else
                e.redir.target = it.npc + it.offset;
            e.csr.addr = caddr;
            e.csr.data = (!it.op[0] && it.op <= OP4) ? a : `XLEN'(rs1);
            case (it.op)
                OP0, OP1: e.csr.op = CSR_WRITE;
                OP2, OP3: e.csr.op = CSR_SET;
                OP4, OP5: e.csr.op = CSR_CLEAR;
                default:  e.csr.op = CSR_NONE;
            endcase
        end
        return e;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Checking

    task automatic check_val(input string what, input logic [`XLEN-1:0] got,
                             input logic [`XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_outputs(input stage_out_t e, input logic with_data);
        check_val("wb.valid", `XLEN'(wb.valid), `XLEN'(e.wb.valid));
        check_val("wb.we", `XLEN'(wb.we), `XLEN'(e.wb.we));
        check_val("mem_req.read", `XLEN'(mem_req.read), `XLEN'(e.mem.read));
        check_val("mem_req.we_mem", `XLEN'(mem_req.we_mem), `XLEN'(e.mem.we_mem));
        check_val("redirect.jump", `XLEN'(redirect.jump), `XLEN'(e.redir.jump));
        check_val("csr_req.rd_en", `XLEN'(csr_req.rd_en), `XLEN'(e.csr.rd_en));
        check_val("csr_req.wr_en", `XLEN'(csr_req.wr_en), `XLEN'(e.csr.wr_en));
        check_val("csr_req.exception", `XLEN'(csr_req.exception), `XLEN'(e.csr.exception));
        if (with_data) begin                        // Data unknown before the first valid
            check_val("wb.result", wb.result, e.wb.result);
            check_val("mem_req.read_address", mem_req.read_address, e.mem.read_address);
            check_val("mem_req.write_address", mem_req.write_address, e.mem.write_address);
            check_val("mem_req.write_data", mem_req.write_data, e.mem.write_data);
            check_val("redirect.target", redirect.target, e.redir.target);
            check_val("csr_req.op", `XLEN'(csr_req.op), `XLEN'(e.csr.op));
            check_val("csr_req.addr", `XLEN'(csr_req.addr), `XLEN'(e.csr.addr));
            check_val("csr_req.data", csr_req.data, e.csr.data);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Processes

    initial begin : drive
        issue_t     nxt;
        privilege_t pv;
        issue     = reset_issue(0);
        privilege = PRIV_MACHINE;
        for (int k = 1; k <= RESET_CYCLES; k++) begin
            @(posedge clk);
            #2;
            if (k < RESET_CYCLES)
                issue = reset_issue(k);             // Still inside reset
            else
                issue = '0;                         // Reset released on this skew
        end
        wait (!rst);
        for (int n = 0; n < N_TESTS; n++) begin
            @(posedge clk);
            #2;                                     // Skew after the edge
            nxt       = make_issue();
            pv        = pick_privilege();
            issue     = nxt;
            privilege = pv;
            sent_q.push_back(nxt);
            priv_q.push_back(pv);
        end
        wait (checked == N_TESTS);
        $display("Issues checked %0d, compares %0d, errors %0d", checked, checks, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

    initial begin : compare
        issue_t     it;
        privilege_t pv;
        stage_out_t exp_out;
        logic       data_known;
        exp_out    = '0;                            // Strobes cleared by reset
        data_known = 1'b0;
        repeat (RESET_CYCLES) begin                 // Valid issues must not pass reset
            @(posedge clk);
            #1;
            compare_outputs(exp_out, 1'b0);
        end
        while (checked < N_TESTS) begin
            @(posedge clk);
            #1;                                     // Outputs settled, before next drive
            if (sent_q.size() == 0) begin
                compare_outputs(exp_out, 1'b0);     // Idle cycle right after reset
            end else begin
                it         = sent_q.pop_front();
                pv         = priv_q.pop_front();
                exp_out    = expect_out(it, pv, exp_out);
                data_known = data_known | it.valid;
                compare_outputs(exp_out, data_known);
                checked++;
            end
        end
    end

    initial begin : watchdog
        #(WATCHDOG_NS);
        $display("Watchdog expired before all %0d issues were checked", N_TESTS);
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// File: flist.f
+incdir+logic
logic/execute_pkg.sv
logic/int_alu.sv
logic/branch_unit.sv
logic/load_store_unit.sv
logic/csr_unit.sv
logic/execute.sv
bench/clock_gen.sv
bench/execute_tb.sv

// File: logic/branch_unit.sv
//////////////////////////////////////////////////////////////////////
// Branch unit: condition, target address and JAL/JALR link value
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "execute_config.svh"

module branch_unit (
    input  logic [`XLEN-1:0] op_a,
    input  logic [`XLEN-1:0] op_b,
    input  logic [`XLEN-1:0] offset,             // PC-relative immediate
    input  logic [`XLEN-1:0] npc,
    input  execute_pkg::sub_op op,
    output logic [`XLEN-1:0] target,
    output logic [`XLEN-1:0] link,               // Return address
    output logic             jump,
    output logic             link_we             // JAL/JALR write rd
);
    import execute_pkg::*;

    logic [`XLEN-1:0] sum;
    logic             is_jal;

    assign sum     = op_a + op_b;
    assign is_jal  = (op == OP6) || (op == OP7);
    assign link    = npc + `XLEN'd4;
    assign link_we = is_jal;

    //////////////////////////////////////////////////////////////////////
    // Target

    always_comb begin
        case (op)
            OP6:     target = sum;                          // JAL
            OP7:     target = {sum[`XLEN-1:1], 1'b0};       // JALR, bit 0 cleared
            default: target = npc + offset;                 // Conditional
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Condition

    always_comb begin
        case (op)
            OP0:     jump = (op_a == op_b);                     // BEQ
            OP1:     jump = (op_a != op_b);                     // BNE
            OP2:     jump = ($signed(op_a) < $signed(op_b));    // BLT
            OP3:     jump = (op_a < op_b);                      // BLTU
            OP4:     jump = ($signed(op_a) >= $signed(op_b));   // BGE
            OP5:     jump = (op_a >= op_b);                     // BGEU
            default: jump = 1'b1;                               // Unconditional
        endcase
    end

endmodule

// File: logic/csr_unit.sv
//////////////////////////////////////////////////////////////////////
// CSR access decoder: enables, operation and privilege check.
// The CSR file itself sits outside the stage
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "execute_config.svh"

module csr_unit (
    input  logic [`XLEN-1:0] op_a,               // rs1 value
    input  logic [`XLEN-1:0] instr,
    input  execute_pkg::sub_op op,
    input  execute_pkg::privilege_t privilege,
    output execute_pkg::csr_req_t req
);
    import execute_pkg::*;

    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [11:0] addr;
    logic        rd_en_int;
    logic        wr_en_int;
    logic        read_only;
    logic        exception;

    assign rd   = instr[11:7];
    assign rs1  = instr[19:15];                  // Also the 5 bit immediate
    assign addr = instr[31:20];

    always_comb begin
        case (op)
            OP0, OP1: begin                                 // CSRRW, CSRRWI
                wr_en_int = 1'b1;
                rd_en_int = (rd != 5'd0);
            end
            OP2, OP3, OP4, OP5: begin                       // Set and clear forms
                rd_en_int = 1'b1;
                wr_en_int = (rs1 != 5'd0);
            end
            default: begin
                rd_en_int = 1'b0;
                wr_en_int = 1'b0;
            end
        endcase
    end

    // Top two address bits set marks a read-only CSR
    assign read_only = (addr[11:10] == 2'b11);
    assign exception = (read_only && wr_en_int) || (privilege < addr[9:8]);

    always_comb begin
        req.rd_en     = rd_en_int & ~exception;
        req.wr_en     = wr_en_int & ~exception;
        req.addr      = addr;
        req.exception = exception;
        req.data      = ((op == OP0) || (op == OP2) || (op == OP4)) ?
                        op_a : {{(`XLEN-5){1'b0}}, rs1};    // Immediate zero-extended
        case (op)
            OP0, OP1: req.op = CSR_WRITE;
            OP2, OP3: req.op = CSR_SET;
            OP4, OP5: req.op = CSR_CLEAR;
            default:  req.op = CSR_NONE;
        endcase
    end

endmodule

// File: logic/execute.sv
//////////////////////////////////////////////////////////////////////
// Execute stage top: routes each issue to its unit by class and
// registers writeback, memory, redirect and CSR outputs, 1 cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "execute_config.svh"

module execute (
    input  logic                        clk,
    input  logic                        rst,
    input  execute_pkg::issue_t         issue,
    input  execute_pkg::privilege_t     privilege,
    output execute_pkg::wb_t            wb,
    output execute_pkg::mem_req_t       mem_req,
    output execute_pkg::redirect_t      redirect,
    output execute_pkg::csr_req_t       csr_req
);
    import execute_pkg::*;

    logic [`XLEN-1:0] alu_result;
    logic [`XLEN-1:0] br_target;
    logic [`XLEN-1:0] br_link;
    logic             br_jump;
    logic             br_link_we;
    mem_req_t         lsu_req;                   // Unregistered LSU outputs
    logic             lsu_rb_we;
    csr_req_t         csr_next;
    logic             wb_we_sel;
    logic [`XLEN-1:0] wb_result_sel;

    int_alu u_alu (
        .op_a(issue.op_a), .op_b(issue.op_b), .unit(issue.unit), .op(issue.op),
        .result(alu_result)
    );

    branch_unit u_branch (
        .op_a(issue.op_a), .op_b(issue.op_b), .offset(issue.offset), .npc(issue.npc),
        .op(issue.op), .target(br_target), .link(br_link), .jump(br_jump),
        .link_we(br_link_we)
    );

    load_store_unit u_lsu (
        .op_a(issue.op_a), .op_b(issue.op_b), .store_data(issue.store_data),
        .op(issue.op), .read_address(lsu_req.read_address),
        .write_address(lsu_req.write_address), .write_data(lsu_req.write_data),
        .we_mem(lsu_req.we_mem), .read(lsu_req.read), .rb_we(lsu_rb_we)
    );

    csr_unit u_csr (
        .op_a(issue.op_a), .instr(issue.instr), .op(issue.op),
        .privilege(privilege), .req(csr_next)
    );

    //////////////////////////////////////////////////////////////////////
    // Writeback select by class

    always_comb begin
        case (issue.unit)
            XU_ADDER, XU_LOGIC, XU_SHIFT: begin
                wb_we_sel     = 1'b1;
                wb_result_sel = alu_result;
            end
            XU_BRANCH: begin
                wb_we_sel     = br_link_we;
                wb_result_sel = br_link;                // npc+4
            end
            XU_MEMORY: begin
                wb_we_sel     = lsu_rb_we;              // Load data arrives later
                wb_result_sel = '0;
            end
            XU_CSR: begin
                wb_we_sel     = csr_next.rd_en;         // Value from the CSR file
                wb_result_sel = '0;
            end
            default: begin
                wb_we_sel     = 1'b0;
                wb_result_sel = '0;
            end
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Output registers, strobes cleared on reset, data held when idle

    always_ff @(posedge clk) begin
        if (rst) begin
            wb.valid          <= 1'b0;
            wb.we             <= 1'b0;
            mem_req.read      <= 1'b0;
            mem_req.we_mem    <= 4'b0000;
            redirect.jump     <= 1'b0;
            csr_req.rd_en     <= 1'b0;
            csr_req.wr_en     <= 1'b0;
            csr_req.exception <= 1'b0;
        end else begin
            wb.valid          <= issue.valid;
            wb.we             <= issue.valid & wb_we_sel;
            mem_req.read      <= issue.valid && issue.unit == XU_MEMORY && lsu_req.read;
            mem_req.we_mem    <= (issue.valid && issue.unit == XU_MEMORY) ?
                                 lsu_req.we_mem : 4'b0000;
            redirect.jump     <= issue.valid && issue.unit == XU_BRANCH && br_jump;
            csr_req.rd_en     <= issue.valid && issue.unit == XU_CSR && csr_next.rd_en;
            csr_req.wr_en     <= issue.valid && issue.unit == XU_CSR && csr_next.wr_en;
            csr_req.exception <= issue.valid && issue.unit == XU_CSR && csr_next.exception;
            if (issue.valid) begin
                wb.result             <= wb_result_sel;
                mem_req.read_address  <= lsu_req.read_address;
                mem_req.write_address <= lsu_req.write_address;
                mem_req.write_data    <= lsu_req.write_data;
                redirect.target       <= br_target;
                csr_req.op            <= csr_next.op;
                csr_req.addr          <= csr_next.addr;
                csr_req.data          <= csr_next.data;
            end
        end
    end

endmodule

// File: logic/execute_config.svh
//////////////////////////////////////////////////////////////////////
// Width defines for the execute stage, included by the package
// and by every module that sizes a datapath port
//////////////////////////////////////////////////////////////////////

`ifndef EXECUTE_CONFIG_SVH
`define EXECUTE_CONFIG_SVH

// Data and address width of the core
`define XLEN 32

// Shift amount, low bits of operand B
`define SHAMT_W 5

`endif

// File: logic/execute_pkg.sv
//////////////////////////////////////////////////////////////////////
// Types shared by the execute stage: unit classes, sub-ops and the
// packed structs that carry an issue and the registered results
//////////////////////////////////////////////////////////////////////

`include "execute_config.svh"

package execute_pkg;

    // Which unit handles the instruction
    typedef enum logic [2:0] {
        XU_ADDER, XU_LOGIC, XU_SHIFT, XU_BRANCH, XU_MEMORY, XU_CSR, XU_NONE
    } xu_class;

    typedef enum logic [2:0] {OP0, OP1, OP2, OP3, OP4, OP5, OP6, OP7} sub_op;

    typedef enum logic [1:0] {
        PRIV_USER       = 2'd0,
        PRIV_SUPERVISOR = 2'd1,
        PRIV_MACHINE    = 2'd3
    } privilege_t;

    typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET, CSR_CLEAR} csr_op_t;

    //////////////////////////////////////////////////////////////////////
    // Stage input and outputs

    typedef struct packed {
        logic              valid;
        xu_class           unit;
        sub_op             op;
        logic [`XLEN-1:0]  op_a;
        logic [`XLEN-1:0]  op_b;
        logic [`XLEN-1:0]  offset;       // Branch immediate
        logic [`XLEN-1:0]  npc;          // PC of this instruction
        logic [`XLEN-1:0]  store_data;
        logic [`XLEN-1:0]  instr;        // Raw word, CSR fields
    } issue_t;

    typedef struct packed {
        logic              valid;
        logic              we;
        logic [`XLEN-1:0]  result;
    } wb_t;

    typedef struct packed {
        logic              read;
        logic [`XLEN-1:0]  read_address;
        logic [`XLEN-1:0]  write_address;
        logic [`XLEN-1:0]  write_data;
        logic [3:0]        we_mem;       // Byte lanes
    } mem_req_t;

    typedef struct packed {
        logic              jump;
        logic [`XLEN-1:0]  target;
    } redirect_t;

    typedef struct packed {
        logic              rd_en;
        logic              wr_en;
        csr_op_t           op;
        logic [11:0]       addr;
        logic [`XLEN-1:0]  data;
        logic              exception;
    } csr_req_t;

endpackage

// File: logic/int_alu.sv
//////////////////////////////////////////////////////////////////////
// Integer ALU: adder, logic and shift classes behind one result mux
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "execute_config.svh"

module int_alu (
    input  logic [`XLEN-1:0] op_a,
    input  logic [`XLEN-1:0] op_b,
    input  execute_pkg::xu_class unit,
    input  execute_pkg::sub_op op,
    output logic [`XLEN-1:0] result
);
    import execute_pkg::*;

    logic [`XLEN-1:0]   add_res;
    logic [`XLEN-1:0]   logic_res;
    logic [`XLEN-1:0]   shift_res;
    logic [`SHAMT_W-1:0] shamt;
    logic               lt_s;
    logic               lt_u;

    assign shamt = op_b[`SHAMT_W-1:0];              // Low bits only
    assign lt_s  = $signed(op_a) < $signed(op_b);
    assign lt_u  = op_a < op_b;

    // Adder class
    always_comb begin
        case (op)
            OP3:     add_res = {{(`XLEN-1){1'b0}}, lt_s};   // SLT
            OP2:     add_res = {{(`XLEN-1){1'b0}}, lt_u};   // SLTU
            OP1:     add_res = op_a - op_b;                 // SUB
            default: add_res = op_a + op_b;                 // ADD, ADDI, AUIPC
        endcase
    end

    always_comb begin
        case (op)
            OP0:     logic_res = op_a ^ op_b;       // XOR
            OP1:     logic_res = op_a | op_b;       // OR
            default: logic_res = op_a & op_b;       // AND
        endcase
    end

    always_comb begin
        case (op)
            OP0:     shift_res = op_a << shamt;                      // SLL
            OP1:     shift_res = op_a >> shamt;                      // SRL
            default: shift_res = $unsigned($signed(op_a) >>> shamt); // SRA
        endcase
    end

    // Shared result mux
    always_comb begin
        case (unit)
            XU_ADDER: result = add_res;
            XU_LOGIC: result = logic_res;
            XU_SHIFT: result = shift_res;
            default:  result = '0;                  // Not an ALU class
        endcase
    end

endmodule

// File: logic/load_store_unit.sv
//////////////////////////////////////////////////////////////////////
// Load/store unit: effective address, read strobe and byte lanes.
// Loads only issue the read, returned data is aligned elsewhere
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "execute_config.svh"

module load_store_unit (
    input  logic [`XLEN-1:0] op_a,               // Base
    input  logic [`XLEN-1:0] op_b,               // Offset
    input  logic [`XLEN-1:0] store_data,
    input  execute_pkg::sub_op op,
    output logic [`XLEN-1:0] read_address,
    output logic [`XLEN-1:0] write_address,
    output logic [`XLEN-1:0] write_data,
    output logic [3:0]       we_mem,
    output logic             read,
    output logic             rb_we               // Loads write rd
);
    import execute_pkg::*;

    logic [`XLEN-1:0] eff_addr;
    logic             is_load;

    assign eff_addr = op_a + op_b;
    assign is_load  = (op == OP0) || (op == OP1) || (op == OP2) ||
                      (op == OP3) || (op == OP4);    // LB LBU LH LHU LW

    assign read          = is_load;
    assign rb_we         = is_load;                  // Stores never write rd
    assign read_address  = is_load ? eff_addr : '0;
    assign write_address = eff_addr;

    // Store lanes, zero padded above the stored size
    always_comb begin
        case (op)
            OP7: begin                                      // SB
                we_mem     = 4'b0001;
                write_data = {{(`XLEN-8){1'b0}}, store_data[7:0]};
            end
            OP6: begin                                      // SH
                we_mem     = 4'b0011;
                write_data = {{(`XLEN-16){1'b0}}, store_data[15:0]};
            end
            OP5: begin                                      // SW
                we_mem     = 4'b1111;
                write_data = store_data;
            end
            default: begin                                  // Loads
                we_mem     = 4'b0000;
                write_data = '0;
            end
        endcase
    end

endmodule
